// File: src/bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int VGA_DATA_W = 24;

  // chip select codes
  typedef enum logic [7:0] {
    CS_NONE = 8'h00,
    CS_RAM  = 8'h03,
    CS_IO   = 8'h04
  } chipsel_t;

  // top address nibble of each region
  localparam logic [3:0] REGION_BOOT = 4'h0;
  localparam logic [3:0] REGION_RAM  = 4'h3;
  localparam logic [3:0] REGION_IO   = 4'h4;

  // scratch ram word index is address bits 11:2
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // i/o block
  localparam logic [DATA_W-1:0] IO_ID = 32'hb0e5_0a01;
  localparam int IO_LED_W = 18;
  localparam int SW_W     = 16;

  // i/o register word index
  localparam logic [1:0] IO_REG_LED = 2'd0;
  localparam logic [1:0] IO_REG_SW  = 2'd1;
  localparam logic [1:0] IO_REG_ID  = 2'd2;

endpackage : bus_pkg

// File: src/bus_arbiter.sv
module bus_arbiter import bus_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic [ADDR_W-1:0]     cpu_address,
  input  logic                  cpu_read,
  input  logic                  cpu_write,
  input  logic [DATA_W-1:0]     cpu_writedata,
  input  logic [BE_W-1:0]       cpu_be,
  input  logic [ADDR_W-1:0]     vga_address,
  input  logic                  vga_read,
  input  logic [DATA_W-1:0]     bm_readdata,
  output logic [DATA_W-1:0]     cpu_readdata,
  output logic                  cpu_wait,
  output logic [VGA_DATA_W-1:0] vga_readdata,
  output logic                  vga_wait,
  output logic [ADDR_W-1:0]     bm_address,
  output logic                  bm_read,
  output logic                  bm_write,
  output logic [DATA_W-1:0]     bm_writedata,
  output logic [BE_W-1:0]       bm_be
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STROBE,
    ST_RESPOND
  } arb_state_t;

  arb_state_t state;
  logic       owner_vga;
  logic       cpu_req;
  logic       respond;

  assign cpu_req = cpu_read | cpu_write;
  assign respond = (state == ST_RESPOND);

  // display fetch wins a tie
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      owner_vga <= 1'b0;
      bm_read   <= 1'b0;
      bm_write  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (vga_read) begin
            state     <= ST_STROBE;
            owner_vga <= 1'b1;
            bm_read   <= 1'b1;
          end else if (cpu_req) begin
            state     <= ST_STROBE;
            owner_vga <= 1'b0;
            bm_read   <= cpu_read;
            bm_write  <= cpu_write & ~cpu_read;
          end
        end
        ST_STROBE: begin
          state    <= ST_RESPOND;
          bm_read  <= 1'b0;
          bm_write <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address and data held from acceptance until the next one
  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      if (vga_read) begin
        bm_address   <= vga_address;
        bm_writedata <= '0;
        bm_be        <= '1;
      end else if (cpu_req) begin
        bm_address   <= cpu_address;
        bm_writedata <= cpu_writedata;
        bm_be        <= cpu_be;
      end
    end
  end

  assign cpu_wait = cpu_req & ~(respond & ~owner_vga);
  assign vga_wait = vga_read & ~(respond & owner_vga);

  assign cpu_readdata = (respond && !owner_vga) ? bm_readdata : '0;
  assign vga_readdata = (respond && owner_vga) ? bm_readdata[VGA_DATA_W-1:0] : '0;

  a_strobe_excl: assert property (@(posedge clock) disable iff (!rst_n)
    !(bm_read && bm_write));

  a_strobe_single: assert property (@(posedge clock) disable iff (!rst_n)
    (bm_read || bm_write) |=> !(bm_read || bm_write));

endmodule : bus_arbiter

// File: src/addr_decode.sv
module addr_decode import bus_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] bm_address,
  input  logic              map,
  output chipsel_t          chipselect,
  output chipsel_t          chipselect_q
);

  logic [3:0] region;

  assign region = bm_address[ADDR_W-1:ADDR_W-4];

  // boot region aliases the scratch ram when map is set
  always_comb begin
    case (region)
      REGION_RAM: chipselect = CS_RAM;
      REGION_IO: chipselect = CS_IO;
      REGION_BOOT: chipselect = map ? CS_RAM : CS_NONE;
      default: chipselect = CS_NONE;
    endcase
  end

  // bm_address only moves at acceptance, so in the respond cycle
  // this holds the code seen during the strobe
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      chipselect_q <= CS_NONE;
    end else begin
      chipselect_q <= chipselect;
    end
  end

  a_cs_legal: assert property (@(posedge clock) disable iff (!rst_n)
    chipselect inside {CS_NONE, CS_RAM, CS_IO});

endmodule : addr_decode

// File: src/scratch_ram.sv
module scratch_ram import bus_pkg::*; (
  input  logic              clock,
  input  chipsel_t          chipselect,
  input  logic              bm_read,
  input  logic              bm_write,
  input  logic [ADDR_W-1:0] bm_address,
  input  logic [DATA_W-1:0] bm_writedata,
  input  logic [BE_W-1:0]   bm_be,
  output logic [DATA_W-1:0] ram_readdata
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic              ram_read;
  logic              ram_write;

  assign word_idx  = bm_address[RAM_AW+1:2];
  assign ram_read  = (chipselect == CS_RAM) && bm_read;
  assign ram_write = (chipselect == CS_RAM) && bm_write;

  // per-byte write enables
  always_ff @(posedge clock) begin
    if (ram_write) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bm_be[b]) begin
          mem[word_idx][8*b +: 8] <= bm_writedata[8*b +: 8];
        end
      end
    end
  end

  // read port only updates on a selected read
  always_ff @(posedge clock) begin
    if (ram_read) begin
      ram_readdata <= mem[word_idx];
    end
  end

endmodule : scratch_ram

// File: src/io_regs.sv
module io_regs import bus_pkg::*; (
  input  logic                clock,
  input  logic                rst_n,
  input  chipsel_t            chipselect,
  input  logic                bm_read,
  input  logic                bm_write,
  input  logic [ADDR_W-1:0]   bm_address,
  input  logic [DATA_W-1:0]   bm_writedata,
  input  logic [BE_W-1:0]     bm_be,
  input  logic [SW_W-1:0]     sw,
  output logic [DATA_W-1:0]   io_readdata,
  output logic [IO_LED_W-1:0] ledr
);

  logic              io_read;
  logic              io_write;
  logic [1:0]        reg_idx;
  logic [DATA_W-1:0] led_merged;

  assign io_read  = (chipselect == CS_IO) && bm_read;
  assign io_write = (chipselect == CS_IO) && bm_write;
  assign reg_idx  = bm_address[3:2];

  // merge enabled bytes into the current led value
  always_comb begin
    led_merged = DATA_W'(ledr);
    for (int b = 0; b < BE_W; b++) begin
      if (bm_be[b]) begin
        led_merged[8*b +: 8] = bm_writedata[8*b +: 8];
      end
    end
  end

  // only word 0 is writable
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ledr <= '0;
    end else if (io_write && reg_idx == IO_REG_LED) begin
      ledr <= led_merged[IO_LED_W-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (io_read) begin
      case (reg_idx)
        IO_REG_LED: io_readdata <= DATA_W'(ledr);
        IO_REG_SW: io_readdata <= DATA_W'(sw);
        IO_REG_ID: io_readdata <= IO_ID;
        default: io_readdata <= '0;
      endcase
    end
  end

endmodule : io_regs

// File: src/read_mux.sv
module read_mux import bus_pkg::*; (
  input  chipsel_t          chipselect_q,
  input  logic [DATA_W-1:0] ram_readdata,
  input  logic [DATA_W-1:0] io_readdata,
  output logic [DATA_W-1:0] bm_readdata
);

  logic [DATA_W-1:0] ram_gated;
  logic [DATA_W-1:0] io_gated;

  // unmapped reads come back as zero
  assign ram_gated = (chipselect_q == CS_RAM) ? ram_readdata : '0;
  assign io_gated  = (chipselect_q == CS_IO) ? io_readdata : '0;

  assign bm_readdata = ram_gated | io_gated;

endmodule : read_mux

// File: src/bus_fabric.sv
module bus_fabric import bus_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  map,
  input  logic [SW_W-1:0]       sw,
  input  logic [ADDR_W-1:0]     cpu_address,
  input  logic                  cpu_read,
  input  logic                  cpu_write,
  input  logic [DATA_W-1:0]     cpu_writedata,
  input  logic [BE_W-1:0]       cpu_be,
  input  logic [ADDR_W-1:0]     vga_address,
  input  logic                  vga_read,
  output logic [DATA_W-1:0]     cpu_readdata,
  output logic                  cpu_wait,
  output logic [VGA_DATA_W-1:0] vga_readdata,
  output logic                  vga_wait,
  output logic [IO_LED_W-1:0]   ledr
);

  logic [ADDR_W-1:0] bm_address;
  logic              bm_read;
  logic              bm_write;
  logic [DATA_W-1:0] bm_writedata;
  logic [BE_W-1:0]   bm_be;
  logic [DATA_W-1:0] bm_readdata;
  logic [DATA_W-1:0] ram_readdata;
  logic [DATA_W-1:0] io_readdata;
  chipsel_t          chipselect;
  chipsel_t          chipselect_q;

  bus_arbiter i_bus_arbiter (
    .clock         (clock),
    .rst_n         (rst_n),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .bm_readdata   (bm_readdata),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .vga_readdata  (vga_readdata),
    .vga_wait      (vga_wait),
    .bm_address    (bm_address),
    .bm_read       (bm_read),
    .bm_write      (bm_write),
    .bm_writedata  (bm_writedata),
    .bm_be         (bm_be)
  );

  addr_decode i_addr_decode (
    .clock        (clock),
    .rst_n        (rst_n),
    .bm_address   (bm_address),
    .map          (map),
    .chipselect   (chipselect),
    .chipselect_q (chipselect_q)
  );

  scratch_ram i_scratch_ram (
    .clock        (clock),
    .chipselect   (chipselect),
    .bm_read      (bm_read),
    .bm_write     (bm_write),
    .bm_address   (bm_address),
    .bm_writedata (bm_writedata),
    .bm_be        (bm_be),
    .ram_readdata (ram_readdata)
  );

  io_regs i_io_regs (
    .clock        (clock),
    .rst_n        (rst_n),
    .chipselect   (chipselect),
    .bm_read      (bm_read),
    .bm_write     (bm_write),
    .bm_address   (bm_address),
    .bm_writedata (bm_writedata),
    .bm_be        (bm_be),
    .sw           (sw),
    .io_readdata  (io_readdata),
    .ledr         (ledr)
  );

  read_mux i_read_mux (
    .chipselect_q (chipselect_q),
    .ram_readdata (ram_readdata),
    .io_readdata  (io_readdata),
    .bm_readdata  (bm_readdata)
  );

endmodule : bus_fabric

// File: verification/bus_checker.sv
module bus_checker import bus_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  map,
  input  logic [SW_W-1:0]       sw,
  input  logic [ADDR_W-1:0]     cpu_address,
  input  logic                  cpu_read,
  input  logic                  cpu_write,
  input  logic [DATA_W-1:0]     cpu_writedata,
  input  logic [BE_W-1:0]       cpu_be,
  input  logic [DATA_W-1:0]     cpu_readdata,
  input  logic                  cpu_wait,
  input  logic [ADDR_W-1:0]     vga_address,
  input  logic                  vga_read,
  input  logic [VGA_DATA_W-1:0] vga_readdata,
  input  logic                  vga_wait,
  input  logic [IO_LED_W-1:0]   ledr,
  output int                    errors,
  output int                    checks
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0]   ram_model [RAM_WORDS];
  logic [IO_LED_W-1:0] led_model;
  logic [DATA_W-1:0]   exp_word;

  initial begin
    errors = 0;
    checks = 0;
  end

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] word;
    word = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // memory map as seen by a master
  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    logic [3:0] region;
    region = addr[ADDR_W-1:ADDR_W-4];
    if (region == REGION_RAM || (region == REGION_BOOT && map)) begin
      return ram_model[addr[11:2]];
    end
    if (region == REGION_IO) begin
      case (addr[3:2])
        2'd0: return DATA_W'(led_model);
        2'd1: return DATA_W'(sw);
        2'd2: return IO_ID;
        default: return '0;
      endcase
    end
    return '0;
  endfunction

  task automatic apply_write();
    logic [3:0] region;
    region = cpu_address[ADDR_W-1:ADDR_W-4];
    if (region == REGION_RAM || (region == REGION_BOOT && map)) begin
      ram_model[cpu_address[11:2]] = merge_bytes(ram_model[cpu_address[11:2]],
                                                 cpu_writedata, cpu_be);
    end else if (region == REGION_IO && cpu_address[3:2] == 2'd0) begin
      led_model = IO_LED_W'(merge_bytes(DATA_W'(led_model), cpu_writedata, cpu_be));
    end
  endtask

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0d ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // values seen here are the ones the DUT flops sample at this edge
  always @(posedge clock) begin
    if (!rst_n) begin
      led_model = '0;
    end else begin
      if (vga_read && !vga_wait) begin
        exp_word = expected_read(vga_address);
        compare("vga_readdata", {8'h00, vga_readdata}, {8'h00, exp_word[VGA_DATA_W-1:0]});
      end
      if ((cpu_read || cpu_write) && !cpu_wait) begin
        if (vga_read && vga_wait) begin
          errors++;
          $display("at %0d ns the cpu finished while a display read was still pending",
                   $time);
        end
        if (cpu_read) begin
          compare("cpu_readdata", cpu_readdata, expected_read(cpu_address));
        end else begin
          apply_write();
        end
        compare("ledr", DATA_W'(ledr), DATA_W'(led_model));
      end
    end
  end

endmodule : bus_checker

// File: verification/tb_bus_fabric.sv
module tb_bus_fabric import bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_ENTRIES = 64;
  localparam int WAIT_LIMIT  = 20;
  localparam int SWEEP_WORDS = 8;

  typedef enum logic [1:0] {
    MST_CPU,
    MST_VGA,
    MST_BOTH
  } master_t;

  typedef struct packed {
    master_t           master;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic              map;
    logic [SW_W-1:0]   sw;
  } entry_t;

  logic                  clock;
  logic                  rst_n;
  logic                  map;
  logic [SW_W-1:0]       sw;
  logic [ADDR_W-1:0]     cpu_address;
  logic                  cpu_read;
  logic                  cpu_write;
  logic [DATA_W-1:0]     cpu_writedata;
  logic [BE_W-1:0]       cpu_be;
  logic [ADDR_W-1:0]     vga_address;
  logic                  vga_read;
  logic [DATA_W-1:0]     cpu_readdata;
  logic                  cpu_wait;
  logic [VGA_DATA_W-1:0] vga_readdata;
  logic                  vga_wait;
  logic [IO_LED_W-1:0]   ledr;

  entry_t stim [MAX_ENTRIES];
  int     n_entries;
  integer seed;
  int     tb_errors;
  int     chk_errors;
  int     chk_checks;
  logic   timed_out;

  bus_fabric i_bus_fabric (
    .clock         (clock),
    .rst_n         (rst_n),
    .map           (map),
    .sw            (sw),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .vga_readdata  (vga_readdata),
    .vga_wait      (vga_wait),
    .ledr          (ledr)
  );

  bus_checker i_bus_checker (
    .clock         (clock),
    .rst_n         (rst_n),
    .map           (map),
    .sw            (sw),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .vga_readdata  (vga_readdata),
    .vga_wait      (vga_wait),
    .ledr          (ledr),
    .errors        (chk_errors),
    .checks        (chk_checks)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [ADDR_W-1:0] word_addr(input logic [3:0] region, input int idx);
    return {region, 16'h0000, 12'(idx << 2)};
  endfunction

  function automatic string master_name(input master_t m);
    case (m)
      MST_CPU: return "cpu";
      MST_VGA: return "vga";
      default: return "both";
    endcase
  endfunction

  function automatic void add_entry(input master_t m, input logic wr,
                                    input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                                    input logic [DATA_W-1:0] wdata, input logic map_val,
                                    input logic [SW_W-1:0] sw_val);
    entry_t e;
    e.master = m;
    e.write  = wr;
    e.addr   = addr;
    e.be     = be;
    e.wdata  = wdata;
    e.map    = map_val;
    e.sw     = sw_val;
    stim[n_entries] = e;
    n_entries++;
  endfunction

  task automatic build_stimulus();
    logic [DATA_W-1:0] fill;
    logic [BE_W-1:0]   part_be [4];
    int                idx;
    n_entries  = 0;
    part_be[0] = 4'b0001;
    part_be[1] = 4'b0010;
    part_be[2] = 4'b1100;
    part_be[3] = 4'b0000;
    // random fill spread over the whole ram and read back
    for (int i = 0; i < SWEEP_WORDS; i++) begin
      idx  = (i * 131 + 5) % RAM_WORDS;
      fill = $random(seed);
      add_entry(MST_CPU, 1'b1, word_addr(REGION_RAM, idx), 4'hf, fill, 1'b0, 16'h0);
    end
    for (int i = 0; i < SWEEP_WORDS; i++) begin
      idx = (i * 131 + 5) % RAM_WORDS;
      add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, idx), 4'hf, '0, 1'b0, 16'h0);
    end
    // partial byte writes with the last one enabling no bytes
    for (int i = 0; i < 4; i++) begin
      idx  = (i * 131 + 5) % RAM_WORDS;
      fill = $random(seed);
      add_entry(MST_CPU, 1'b1, word_addr(REGION_RAM, idx), part_be[i], fill, 1'b0, 16'h0);
    end
    for (int i = 0; i < 4; i++) begin
      idx = (i * 131 + 5) % RAM_WORDS;
      add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, idx), 4'hf, '0, 1'b0, 16'h0);
    end
    // boot region alias
    add_entry(MST_CPU, 1'b0, word_addr(REGION_BOOT, 5), 4'hf, '0, 1'b1, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_BOOT, 529), 4'hf, '0, 1'b1, 16'h0);
    add_entry(MST_VGA, 1'b0, word_addr(REGION_BOOT, 660), 4'hf, '0, 1'b1, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_BOOT, 791), 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b1, word_addr(REGION_BOOT, 791), 4'hf, $random(seed), 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, 791), 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b1, word_addr(REGION_BOOT, 922), 4'hf, $random(seed), 1'b1, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, 922), 4'hf, '0, 1'b0, 16'h0);
    // i/o block
    add_entry(MST_CPU, 1'b1, word_addr(REGION_IO, 0), 4'hf, 32'hfffd_a5c3, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 0), 4'hf, '0, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b1, word_addr(REGION_IO, 0), 4'b0010, 32'h0000_7e00, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 0), 4'hf, '0, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 1), 4'hf, '0, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 2), 4'hf, '0, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 3), 4'hf, '0, 1'b0, 16'h5a3c);
    add_entry(MST_CPU, 1'b1, word_addr(REGION_IO, 1), 4'hf, 32'hffff_ffff, 1'b0, 16'hc3a5);
    add_entry(MST_CPU, 1'b1, word_addr(REGION_IO, 2), 4'hf, 32'h0000_0000, 1'b0, 16'hc3a5);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 1), 4'hf, '0, 1'b0, 16'hc3a5);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_IO, 2), 4'hf, '0, 1'b0, 16'hc3a5);
    add_entry(MST_VGA, 1'b0, word_addr(REGION_IO, 2), 4'hf, '0, 1'b0, 16'hc3a5);
    // both masters in the same cycle
    add_entry(MST_BOTH, 1'b0, word_addr(REGION_RAM, 136), 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_BOTH, 1'b1, word_addr(REGION_RAM, 529), 4'hf, $random(seed), 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, 529), 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_BOTH, 1'b0, word_addr(REGION_IO, 0), 4'hf, '0, 1'b0, 16'h0);
    // unmapped region
    add_entry(MST_CPU, 1'b0, 32'h8000_0014, 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b1, 32'h8000_0014, 4'hf, $random(seed), 1'b0, 16'h0);
    add_entry(MST_CPU, 1'b0, word_addr(REGION_RAM, 5), 4'hf, '0, 1'b0, 16'h0);
    add_entry(MST_VGA, 1'b0, 32'h7000_0000, 4'hf, '0, 1'b0, 16'h0);
  endtask

  task automatic drive_entry(input entry_t e);
    map = e.map;
    sw  = e.sw;
    if (e.master != MST_VGA) begin
      cpu_address   = e.addr;
      cpu_read      = ~e.write;
      cpu_write     = e.write;
      cpu_writedata = e.wdata;
      cpu_be        = e.be;
    end
    if (e.master != MST_CPU) begin
      vga_address = e.addr;
      vga_read    = 1'b1;
    end
  endtask

  // counts falling edges until the chosen wait is seen low
  task automatic wait_for_done(input logic for_vga, input int test_no, output int cycles,
                               output logic ok);
    logic busy;
    cycles = 0;
    ok     = 1'b1;
    busy   = 1'b1;
    while (busy) begin
      @(negedge clock);
      cycles++;
      busy = for_vga ? vga_wait : cpu_wait;
      if (busy && cycles >= WAIT_LIMIT) begin
        $display("test %0d timed out waiting for %s to go low", test_no,
                 for_vga ? "vga_wait" : "cpu_wait");
        ok   = 1'b0;
        busy = 1'b0;
      end
    end
  endtask

  // accepted at the first edge and wait low from the second one
  task automatic check_latency(input string name, input int cycles);
    if (cycles != 2) begin
      tb_errors++;
      $display("ERR %0d ns %s cycles got %0d expected 2", $time, name, cycles);
    end
  endtask

  task automatic check_idle_waits();
    repeat (3) begin
      @(negedge clock);
      if (cpu_wait !== 1'b0) begin
        tb_errors++;
        $display("ERR %0d ns cpu_wait got %b expected 0", $time, cpu_wait);
      end
      if (vga_wait !== 1'b0) begin
        tb_errors++;
        $display("ERR %0d ns vga_wait got %b expected 0", $time, vga_wait);
      end
    end
  endtask

  task automatic run_entry(input int n, output logic ok);
    entry_t e;
    int     cycles;
    int     errs_before;
    e           = stim[n];
    errs_before = chk_errors + tb_errors;
    ok          = 1'b1;
    drive_entry(e);
    if (e.master != MST_CPU) begin
      wait_for_done(1'b1, n, cycles, ok);
      if (ok) begin
        check_latency("vga_wait", cycles);
        @(negedge clock);
        vga_read = 1'b0;
      end
    end
    if (ok && e.master != MST_VGA) begin
      wait_for_done(1'b0, n, cycles, ok);
      if (ok) begin
        check_latency("cpu_wait", cycles);
        @(negedge clock);
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
      end
    end
    if (ok) begin
      $display("test %0d %s %s addr %h: %s", n, master_name(e.master),
               e.write ? "write" : "read", e.addr,
               (chk_errors + tb_errors == errs_before) ? "ok" : "FAIL");
    end
  endtask

  initial begin
    logic ok;
    int   total;
    seed          = 32'h8eeefbdc;
    rst_n         = 1'b0;
    map           = 1'b0;
    sw            = '0;
    cpu_address   = '0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    cpu_writedata = '0;
    cpu_be        = '0;
    vga_address   = '0;
    vga_read      = 1'b0;
    tb_errors     = 0;
    timed_out     = 1'b0;
    build_stimulus();
    repeat (2) @(negedge clock);
    rst_n = 1'b1;
    check_idle_waits();
    for (int n = 0; n < n_entries; n++) begin
      run_entry(n, ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
    end
    total = chk_errors + tb_errors;
    $display("tests %0d, checks %0d, errors %0d, timeouts %0d", n_entries, chk_checks,
             total, timed_out);
    if (total == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_bus_fabric

// File: tb.f
src/bus_pkg.sv
src/bus_arbiter.sv
src/addr_decode.sv
src/scratch_ram.sv
src/io_regs.sv
src/read_mux.sv
src/bus_fabric.sv
verification/bus_checker.sv
verification/tb_bus_fabric.sv

// File: Bender.yml
package:
  name: bus_fabric

sources:
  - src/bus_pkg.sv
  - src/bus_arbiter.sv
  - src/addr_decode.sv
  - src/scratch_ram.sv
  - src/io_regs.sv
  - src/read_mux.sv
  - src/bus_fabric.sv
  - target: test
    files:
      - verification/bus_checker.sv
      - verification/tb_bus_fabric.sv
